// ==== hw/net_pkg.sv ====
package net_pkg;

  // Address widths
  localparam int ip_addr_bits  = 32;
  localparam int mac_addr_bits = 48;

  // ARP lookup request, user to network
  typedef struct packed {
    logic [ip_addr_bits-1:0] ip;
  } arp_req_t;

  // ARP lookup reply, network to user
  typedef struct packed {
    logic                     hit;
    logic [mac_addr_bits-1:0] mac;
    // IP that was looked up, echoed back
    logic [ip_addr_bits-1:0]  ip;
  } arp_rsp_t;

  // Lookup statistics, refreshed every cycle
  typedef struct packed {
    logic [31:0] lookups;
    logic [31:0] hits;
  } net_stat_t;

  // APB request side
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // APB response side
  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
  } apb_rsp_t;

endpackage

// ==== hw/axis_reg_slice.sv ====
`timescale 1ns/1ps

module axis_reg_slice #(
  parameter int DATA_BITS = 32
) (
  input  logic                 aclk,
  input  logic                 rst_n,
  input  logic                 s_valid,
  output logic                 s_ready,
  input  logic [DATA_BITS-1:0] s_data,
  output logic                 m_valid,
  input  logic                 m_ready,
  output logic [DATA_BITS-1:0] m_data
);

  // Second entry, filled only when the output stalls
  logic                 skid_valid;
  logic [DATA_BITS-1:0] skid_data;
  logic                 out_free;

  // Output register empty or draining this cycle
  assign out_free = m_ready || !m_valid;

  // Ready straight from a flop, low only with both entries full
  assign s_ready = !skid_valid;

  // Control state
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      // Skid entry drains first to keep order
      if (skid_valid) begin
        m_valid    <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        m_valid <= s_valid;
      end
    end else if (s_valid && s_ready) begin
      // Output stalled, park the new word
      skid_valid <= 1'b1;
    end
  end

  // Payload
  always_ff @(posedge aclk) begin
    if (out_free) begin
      if (skid_valid) begin
        m_data <= skid_data;
      end else if (s_valid) begin
        m_data <= s_data;
      end
    end else if (s_valid && s_ready) begin
      skid_data <= s_data;
    end
  end

endmodule

// ==== hw/net_slice_array.sv ====
`timescale 1ns/1ps

module net_slice_array #(
  parameter int N_STAGES = 2
) (
  input  logic                                aclk,
  input  logic                                rst_n,
  // User side
  input  logic                                arp_req_u_valid,
  output logic                                arp_req_u_ready,
  input  net_pkg::arp_req_t                   arp_req_u,
  output logic                                arp_rsp_u_valid,
  input  logic                                arp_rsp_u_ready,
  output net_pkg::arp_rsp_t                   arp_rsp_u,
  input  logic                                set_ip_u_valid,
  output logic                                set_ip_u_ready,
  input  logic [net_pkg::ip_addr_bits-1:0]    set_ip_u,
  input  logic                                set_mac_u_valid,
  output logic                                set_mac_u_ready,
  input  logic [net_pkg::mac_addr_bits-1:0]   set_mac_u,
  output net_pkg::net_stat_t                  stats_u,
  // Network side
  output logic                                arp_req_n_valid,
  input  logic                                arp_req_n_ready,
  output net_pkg::arp_req_t                   arp_req_n,
  input  logic                                arp_rsp_n_valid,
  output logic                                arp_rsp_n_ready,
  input  net_pkg::arp_rsp_t                   arp_rsp_n,
  output logic                                set_ip_n_valid,
  input  logic                                set_ip_n_ready,
  output logic [net_pkg::ip_addr_bits-1:0]    set_ip_n,
  output logic                                set_mac_n_valid,
  input  logic                                set_mac_n_ready,
  output logic [net_pkg::mac_addr_bits-1:0]   set_mac_n,
  input  net_pkg::net_stat_t                  stats_n
);

  // Index 0 is the upstream end of each stream
  logic [N_STAGES:0]                                  req_v, req_r, rsp_v, rsp_r;
  logic [N_STAGES:0]                                  ip_v, ip_r, mac_v, mac_r;
  net_pkg::arp_req_t [N_STAGES:0]                     req_d;
  net_pkg::arp_rsp_t [N_STAGES:0]                     rsp_d;
  logic [N_STAGES:0][net_pkg::ip_addr_bits-1:0]       ip_d;
  logic [N_STAGES:0][net_pkg::mac_addr_bits-1:0]      mac_d;
  net_pkg::net_stat_t [N_STAGES:0]                    stat_d;

  // Requests and commands flow user to network
  assign req_v[0]        = arp_req_u_valid;
  assign arp_req_u_ready = req_r[0];
  assign req_d[0]        = arp_req_u;
  assign arp_req_n_valid = req_v[N_STAGES];
  assign req_r[N_STAGES] = arp_req_n_ready;
  assign arp_req_n       = req_d[N_STAGES];

  assign ip_v[0]         = set_ip_u_valid;
  assign set_ip_u_ready  = ip_r[0];
  assign ip_d[0]         = set_ip_u;
  assign set_ip_n_valid  = ip_v[N_STAGES];
  assign ip_r[N_STAGES]  = set_ip_n_ready;
  assign set_ip_n        = ip_d[N_STAGES];

  assign mac_v[0]        = set_mac_u_valid;
  assign set_mac_u_ready = mac_r[0];
  assign mac_d[0]        = set_mac_u;
  assign set_mac_n_valid = mac_v[N_STAGES];
  assign mac_r[N_STAGES] = set_mac_n_ready;
  assign set_mac_n       = mac_d[N_STAGES];

  // Replies and stats flow network to user
  assign rsp_v[0]        = arp_rsp_n_valid;
  assign arp_rsp_n_ready = rsp_r[0];
  assign rsp_d[0]        = arp_rsp_n;
  assign arp_rsp_u_valid = rsp_v[N_STAGES];
  assign rsp_r[N_STAGES] = arp_rsp_u_ready;
  assign arp_rsp_u       = rsp_d[N_STAGES];

  assign stat_d[0] = stats_n;
  assign stats_u   = stat_d[N_STAGES];

  for (genvar i = 0; i < N_STAGES; i++) begin : g_stage
    // ARP request
    axis_reg_slice #(.DATA_BITS($bits(net_pkg::arp_req_t))) u_req (
      .aclk, .rst_n,
      .s_valid(req_v[i]), .s_ready(req_r[i]), .s_data(req_d[i]),
      .m_valid(req_v[i+1]), .m_ready(req_r[i+1]), .m_data(req_d[i+1])
    );

    // ARP reply
    axis_reg_slice #(.DATA_BITS($bits(net_pkg::arp_rsp_t))) u_rsp (
      .aclk, .rst_n,
      .s_valid(rsp_v[i]), .s_ready(rsp_r[i]), .s_data(rsp_d[i]),
      .m_valid(rsp_v[i+1]), .m_ready(rsp_r[i+1]), .m_data(rsp_d[i+1])
    );

    // Set IP
    axis_reg_slice #(.DATA_BITS(net_pkg::ip_addr_bits)) u_ip (
      .aclk, .rst_n,
      .s_valid(ip_v[i]), .s_ready(ip_r[i]), .s_data(ip_d[i]),
      .m_valid(ip_v[i+1]), .m_ready(ip_r[i+1]), .m_data(ip_d[i+1])
    );

    // Set MAC
    axis_reg_slice #(.DATA_BITS(net_pkg::mac_addr_bits)) u_mac (
      .aclk, .rst_n,
      .s_valid(mac_v[i]), .s_ready(mac_r[i]), .s_data(mac_d[i]),
      .m_valid(mac_v[i+1]), .m_ready(mac_r[i+1]), .m_data(mac_d[i+1])
    );

    // Stats level, one cycle per stage and no handshake
    always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
        stat_d[i+1] <= '0;
      end else begin
        stat_d[i+1] <= stat_d[i];
      end
    end
  end

endmodule

// ==== hw/net_cfg_regs.sv ====
`timescale 1ns/1ps

module net_cfg_regs (
  input  logic                              aclk,
  input  logic                              rst_n,
  input  net_pkg::apb_req_t                 apb_req,
  output net_pkg::apb_rsp_t                 apb_rsp,
  output logic                              set_ip_valid,
  input  logic                              set_ip_ready,
  output logic [net_pkg::ip_addr_bits-1:0]  set_ip,
  output logic                              set_mac_valid,
  input  logic                              set_mac_ready,
  output logic [net_pkg::mac_addr_bits-1:0] set_mac,
  output logic                              arp_ins,
  output logic [net_pkg::ip_addr_bits-1:0]  arp_ins_ip,
  output logic [net_pkg::mac_addr_bits-1:0] arp_ins_mac,
  input  net_pkg::net_stat_t                stats
);

  // Register offsets
  localparam logic [7:0] addr_ip          = 8'h00;
  localparam logic [7:0] addr_mac_lo      = 8'h04;
  localparam logic [7:0] addr_mac_hi      = 8'h08;
  localparam logic [7:0] addr_arp_ip      = 8'h0C;
  localparam logic [7:0] addr_arp_mac_lo  = 8'h10;
  localparam logic [7:0] addr_arp_mac_hi  = 8'h14;
  localparam logic [7:0] addr_stat_lookup = 8'h18;
  localparam logic [7:0] addr_stat_hits   = 8'h1C;

  logic                              wr_access;
  logic                              ip_stall;
  logic                              mac_stall;
  logic                              wr_en;
  logic [net_pkg::ip_addr_bits-1:0]  ip_q;
  logic [net_pkg::mac_addr_bits-1:0] mac_q;
  logic [net_pkg::ip_addr_bits-1:0]  arp_ip_q;
  logic [31:0]                       arp_mac_lo_q;

  assign wr_access = apb_req.psel && apb_req.penable && apb_req.pwrite;

  // Hold the access while the previous command of the same kind waits
  assign ip_stall  = wr_access && apb_req.paddr == addr_ip && set_ip_valid && !set_ip_ready;
  assign mac_stall = wr_access && apb_req.paddr == addr_mac_hi
                     && set_mac_valid && !set_mac_ready;
  assign wr_en     = wr_access && !ip_stall && !mac_stall;

  // Response, read mux on the address
  always_comb begin
    apb_rsp.pready = !(ip_stall || mac_stall);
    case (apb_req.paddr)
      addr_ip:          apb_rsp.prdata = ip_q;
      addr_mac_lo:      apb_rsp.prdata = mac_q[31:0];
      addr_mac_hi:      apb_rsp.prdata = {16'h0, mac_q[47:32]};
      addr_arp_ip:      apb_rsp.prdata = arp_ip_q;
      addr_arp_mac_lo:  apb_rsp.prdata = arp_mac_lo_q;
      addr_stat_lookup: apb_rsp.prdata = stats.lookups;
      addr_stat_hits:   apb_rsp.prdata = stats.hits;
      // Write-only and unmapped
      default:          apb_rsp.prdata = '0;
    endcase
  end

  // Config registers and command flags
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      ip_q          <= '0;
      mac_q         <= '0;
      arp_ip_q      <= '0;
      arp_mac_lo_q  <= '0;
      set_ip_valid  <= 1'b0;
      set_mac_valid <= 1'b0;
    end else begin
      // Commands retire on their handshake
      if (set_ip_ready) begin
        set_ip_valid <= 1'b0;
      end
      if (set_mac_ready) begin
        set_mac_valid <= 1'b0;
      end
      if (wr_en) begin
        case (apb_req.paddr)
          addr_ip: begin
            ip_q         <= apb_req.pwdata;
            set_ip_valid <= 1'b1;
          end
          addr_mac_lo: mac_q[31:0] <= apb_req.pwdata;
          addr_mac_hi: begin
            mac_q[47:32]  <= apb_req.pwdata[15:0];
            set_mac_valid <= 1'b1;
          end
          addr_arp_ip:     arp_ip_q     <= apb_req.pwdata;
          addr_arp_mac_lo: arp_mac_lo_q <= apb_req.pwdata;
          default: ;
        endcase
      end
    end
  end

  // Set-MAC payload, frozen so later MAC_LO writes leave it alone
  always_ff @(posedge aclk) begin
    if (wr_en && apb_req.paddr == addr_mac_hi) begin
      set_mac <= {apb_req.pwdata[15:0], mac_q[31:0]};
    end
  end

  // IP only changes once its command is taken
  assign set_ip = ip_q;

  // Insert strobe during the ARP_MAC_HI access, table updates on that edge
  assign arp_ins     = wr_en && apb_req.paddr == addr_arp_mac_hi;
  assign arp_ins_ip  = arp_ip_q;
  assign arp_ins_mac = {apb_req.pwdata[15:0], arp_mac_lo_q};

endmodule

// ==== hw/arp_cache.sv ====
`timescale 1ns/1ps

module arp_cache #(
  parameter int ARP_ENTRIES = 4
) (
  input  logic                              aclk,
  input  logic                              rst_n,
  input  logic                              req_valid,
  output logic                              req_ready,
  input  net_pkg::arp_req_t                 req,
  output logic                              rsp_valid,
  input  logic                              rsp_ready,
  output net_pkg::arp_rsp_t                 rsp,
  input  logic                              ins,
  input  logic [net_pkg::ip_addr_bits-1:0]  ins_ip,
  input  logic [net_pkg::mac_addr_bits-1:0] ins_mac,
  output net_pkg::net_stat_t                stats
);

  localparam int idx_bits = (ARP_ENTRIES > 1) ? $clog2(ARP_ENTRIES) : 1;

  // Table, only the valid bits are control state
  logic [ARP_ENTRIES-1:0]            tbl_valid;
  logic [net_pkg::ip_addr_bits-1:0]  tbl_ip [ARP_ENTRIES];
  logic [net_pkg::mac_addr_bits-1:0] tbl_mac [ARP_ENTRIES];
  logic [idx_bits-1:0]               rr_ptr;
  logic [idx_bits-1:0]               ins_idx;
  logic                              ins_match;
  logic                              lup_hit;
  logic [net_pkg::mac_addr_bits-1:0] lup_mac;
  logic                              req_fire;
  logic [31:0]                       lookups;
  logic [31:0]                       hits;

  // Lookup across all entries at once
  always_comb begin
    lup_hit = 1'b0;
    lup_mac = '0;
    for (int i = 0; i < ARP_ENTRIES; i++) begin
      if (tbl_valid[i] && tbl_ip[i] == req.ip) begin
        lup_hit = 1'b1;
        lup_mac = tbl_mac[i];
      end
    end
  end

  // Insert slot, existing IP else round-robin victim
  always_comb begin
    ins_match = 1'b0;
    ins_idx   = rr_ptr;
    for (int i = 0; i < ARP_ENTRIES; i++) begin
      if (tbl_valid[i] && tbl_ip[i] == ins_ip) begin
        ins_match = 1'b1;
        ins_idx   = idx_bits'(i);
      end
    end
  end

  // One reply register, refilled as it drains
  assign req_ready = !rsp_valid || rsp_ready;
  assign req_fire  = req_valid && req_ready;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      tbl_valid <= '0;
      rr_ptr    <= '0;
      rsp_valid <= 1'b0;
      lookups   <= '0;
      hits      <= '0;
    end else begin
      if (ins) begin
        tbl_valid[ins_idx] <= 1'b1;
        // Pointer moves only on a real replacement
        if (!ins_match) begin
          rr_ptr <= (rr_ptr == idx_bits'(ARP_ENTRIES - 1)) ? '0 : rr_ptr + 1'b1;
        end
      end
      if (req_fire) begin
        rsp_valid <= 1'b1;
        lookups   <= lookups + 1'b1;
        if (lup_hit) begin
          hits <= hits + 1'b1;
        end
      end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
      end
    end
  end

  // Table contents and reply payload
  always_ff @(posedge aclk) begin
    if (ins) begin
      tbl_ip[ins_idx]  <= ins_ip;
      tbl_mac[ins_idx] <= ins_mac;
    end
    if (req_fire) begin
      rsp <= '{hit: lup_hit, mac: lup_mac, ip: req.ip};
    end
  end

  assign stats = '{lookups: lookups, hits: hits};

endmodule

// ==== hw/net_ctrl_top.sv ====
`timescale 1ns/1ps

module net_ctrl_top #(
  parameter int N_STAGES    = 2,
  parameter int ARP_ENTRIES = 4
) (
  input  logic                              aclk,
  input  logic                              rst_n,
  // Configuration
  input  net_pkg::apb_req_t                 apb_req,
  output net_pkg::apb_rsp_t                 apb_rsp,
  // User lookups
  input  logic                              arp_req_u_valid,
  output logic                              arp_req_u_ready,
  input  net_pkg::arp_req_t                 arp_req_u,
  output logic                              arp_rsp_u_valid,
  input  logic                              arp_rsp_u_ready,
  output net_pkg::arp_rsp_t                 arp_rsp_u,
  // Network stack commands
  output logic                              set_ip_n_valid,
  input  logic                              set_ip_n_ready,
  output logic [net_pkg::ip_addr_bits-1:0]  set_ip_n,
  output logic                              set_mac_n_valid,
  input  logic                              set_mac_n_ready,
  output logic [net_pkg::mac_addr_bits-1:0] set_mac_n
);

  // Register block to slice array
  logic                              set_ip_valid, set_ip_ready;
  logic [net_pkg::ip_addr_bits-1:0]  set_ip;
  logic                              set_mac_valid, set_mac_ready;
  logic [net_pkg::mac_addr_bits-1:0] set_mac;
  net_pkg::net_stat_t                stats_cfg;
  // Register block to cache, no back-pressure
  logic                              arp_ins;
  logic [net_pkg::ip_addr_bits-1:0]  arp_ins_ip;
  logic [net_pkg::mac_addr_bits-1:0] arp_ins_mac;
  // Slice array to cache
  logic                              req_valid, req_ready, rsp_valid, rsp_ready;
  net_pkg::arp_req_t                 req;
  net_pkg::arp_rsp_t                 rsp;
  net_pkg::net_stat_t                stats_cache;

  net_cfg_regs u_cfg (
    .aclk, .rst_n, .apb_req, .apb_rsp,
    .set_ip_valid, .set_ip_ready, .set_ip,
    .set_mac_valid, .set_mac_ready, .set_mac,
    .arp_ins, .arp_ins_ip, .arp_ins_mac,
    .stats(stats_cfg)
  );

  net_slice_array #(.N_STAGES(N_STAGES)) u_slices (
    .aclk, .rst_n,
    .arp_req_u_valid, .arp_req_u_ready, .arp_req_u,
    .arp_rsp_u_valid, .arp_rsp_u_ready, .arp_rsp_u,
    .set_ip_u_valid(set_ip_valid), .set_ip_u_ready(set_ip_ready), .set_ip_u(set_ip),
    .set_mac_u_valid(set_mac_valid), .set_mac_u_ready(set_mac_ready), .set_mac_u(set_mac),
    .stats_u(stats_cfg),
    .arp_req_n_valid(req_valid), .arp_req_n_ready(req_ready), .arp_req_n(req),
    .arp_rsp_n_valid(rsp_valid), .arp_rsp_n_ready(rsp_ready), .arp_rsp_n(rsp),
    .set_ip_n_valid, .set_ip_n_ready, .set_ip_n,
    .set_mac_n_valid, .set_mac_n_ready, .set_mac_n,
    .stats_n(stats_cache)
  );

  arp_cache #(.ARP_ENTRIES(ARP_ENTRIES)) u_cache (
    .aclk, .rst_n,
    .req_valid, .req_ready, .req,
    .rsp_valid, .rsp_ready, .rsp,
    .ins(arp_ins), .ins_ip(arp_ins_ip), .ins_mac(arp_ins_mac),
    .stats(stats_cache)
  );

endmodule

// ==== test/net_ctrl_asserts.sv ====
`timescale 1ns/1ps

module net_ctrl_asserts (
  input logic                              aclk,
  input logic                              rst_n,
  input net_pkg::apb_req_t                 apb_req,
  input net_pkg::apb_rsp_t                 apb_rsp,
  input logic                              arp_rsp_u_valid,
  input logic                              arp_rsp_u_ready,
  input net_pkg::arp_rsp_t                 arp_rsp_u,
  input logic                              set_ip_n_valid,
  input logic                              set_ip_n_ready,
  input logic [net_pkg::ip_addr_bits-1:0]  set_ip_n,
  input logic                              set_mac_n_valid,
  input logic                              set_mac_n_ready,
  input logic [net_pkg::mac_addr_bits-1:0] set_mac_n,
  // Last request stage feeding the cache
  input logic                              req_valid,
  input logic                              req_ready,
  input net_pkg::arp_req_t                 req,
  // Pending commands inside the register block
  input logic                              set_ip_valid,
  input logic                              set_mac_valid
);

  // Read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // Streams hold valid and payload until taken
  a_rsp_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    arp_rsp_u_valid && !arp_rsp_u_ready |=> arp_rsp_u_valid && $stable(arp_rsp_u))
    else begin
      fail_count++;
      $error("arp_rsp_u dropped or changed before ready");
    end

  a_ip_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    set_ip_n_valid && !set_ip_n_ready |=> set_ip_n_valid && $stable(set_ip_n))
    else begin
      fail_count++;
      $error("set_ip_n dropped or changed before ready");
    end

  a_mac_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    set_mac_n_valid && !set_mac_n_ready |=> set_mac_n_valid && $stable(set_mac_n))
    else begin
      fail_count++;
      $error("set_mac_n dropped or changed before ready");
    end

  a_req_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    req_valid && !req_ready |=> req_valid && $stable(req))
    else begin
      fail_count++;
      $error("cache request dropped or changed before ready");
    end

  // Everything idle on the first cycle out of reset
  a_reset_idle: assert property (@(posedge aclk)
    $rose(rst_n) |-> !(arp_rsp_u_valid || set_ip_n_valid || set_mac_n_valid || req_valid))
    else begin
      fail_count++;
      $error("valid output high right after reset");
    end

  // Wait states only on a command write that would overwrite a pending one
  a_pready: assert property (@(posedge aclk) disable iff (!rst_n)
    apb_req.psel && apb_req.penable && !apb_rsp.pready |->
      (apb_req.paddr == 8'h00 && set_ip_valid) || (apb_req.paddr == 8'h08 && set_mac_valid))
    else begin
      fail_count++;
      $error("pready low with no matching command pending");
    end

endmodule

bind net_ctrl_top net_ctrl_asserts u_asserts (
  .aclk, .rst_n, .apb_req, .apb_rsp,
  .arp_rsp_u_valid, .arp_rsp_u_ready, .arp_rsp_u,
  .set_ip_n_valid, .set_ip_n_ready, .set_ip_n,
  .set_mac_n_valid, .set_mac_n_ready, .set_mac_n,
  .req_valid, .req_ready, .req,
  .set_ip_valid, .set_mac_valid
);

// ==== test/tb_net_ctrl.sv ====
`timescale 1ns/1ps

module tb_net_ctrl;

  localparam int n_stages    = 2;
  localparam int arp_entries = 4;
  localparam int clk_period  = 8;
  // Cycle budget per test summed for the watchdog
  localparam int watchdog_cycles = 20 + 80 + 400 + 300 + 150 + 400 + 80 + 300;

  localparam logic [7:0] reg_ip      = 8'h00;
  localparam logic [7:0] reg_mac_lo  = 8'h04;
  localparam logic [7:0] reg_mac_hi  = 8'h08;
  localparam logic [7:0] reg_arp_ip  = 8'h0C;
  localparam logic [7:0] reg_arp_lo  = 8'h10;
  localparam logic [7:0] reg_arp_hi  = 8'h14;
  localparam logic [7:0] reg_lookups = 8'h18;
  localparam logic [7:0] reg_hits    = 8'h1C;

  logic                              aclk;
  logic                              rst_n;
  net_pkg::apb_req_t                 apb_req;
  net_pkg::apb_rsp_t                 apb_rsp;
  logic                              arp_req_u_valid, arp_req_u_ready;
  net_pkg::arp_req_t                 arp_req_u;
  logic                              arp_rsp_u_valid, arp_rsp_u_ready;
  net_pkg::arp_rsp_t                 arp_rsp_u;
  logic                              set_ip_n_valid, set_ip_n_ready;
  logic [net_pkg::ip_addr_bits-1:0]  set_ip_n;
  logic                              set_mac_n_valid, set_mac_n_ready;
  logic [net_pkg::mac_addr_bits-1:0] set_mac_n;

  integer seed = 32'h8931;
  int     checks, errors, err_base, stall_seen, reply_count;
  logic   rand_ready;
  // Scoreboard queues and model table
  net_pkg::arp_rsp_t                 rsp_exp[$];
  logic [net_pkg::ip_addr_bits-1:0]  ip_seen[$];
  logic [net_pkg::mac_addr_bits-1:0] mac_seen[$];
  logic                              model_valid [arp_entries];
  logic [net_pkg::ip_addr_bits-1:0]  model_ip [arp_entries];
  logic [net_pkg::mac_addr_bits-1:0] model_mac [arp_entries];
  int                                model_rr, model_lookups, model_hits;

  net_ctrl_top #(.N_STAGES(n_stages), .ARP_ENTRIES(arp_entries)) UUT (
    .aclk, .rst_n, .apb_req, .apb_rsp,
    .arp_req_u_valid, .arp_req_u_ready, .arp_req_u,
    .arp_rsp_u_valid, .arp_rsp_u_ready, .arp_rsp_u,
    .set_ip_n_valid, .set_ip_n_ready, .set_ip_n,
    .set_mac_n_valid, .set_mac_n_ready, .set_mac_n
  );

  initial begin
    aclk = 1'b0;
    forever #(clk_period / 2) aclk = ~aclk;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Timeout: run still going after %0d cycles", watchdog_cycles);
    $display("Checks failed");
    $finish;
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  task automatic step();
    @(posedge aclk);
    #1;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) step();
  endtask

  task automatic expect_eq(input string what, input logic [80:0] got, input logic [80:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s finished, %0d errors", name, errors - err_base);
    err_base = errors;
  endtask

  // One APB transfer sampled late in the cycle
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    step();
    apb_req.penable = 1'b1;
    #6;
    while (!apb_rsp.pready) begin
      stall_seen++;
      step();
      #6;
    end
    rdata = apb_rsp.prdata;
    step();
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    apb_access(1'b0, addr, '0, data);
  endtask

  // Existing IP keeps its slot and a new IP takes the round-robin victim
  task automatic insert_entry(input logic [31:0] ip, input logic [47:0] mac);
    int   slot;
    logic found;
    apb_write(reg_arp_ip, ip);
    apb_write(reg_arp_lo, mac[31:0]);
    apb_write(reg_arp_hi, {16'h0, mac[47:32]});
    found = 1'b0;
    slot  = model_rr;
    for (int i = 0; i < arp_entries; i++) begin
      if (model_valid[i] && model_ip[i] == ip) begin
        found = 1'b1;
        slot  = i;
      end
    end
    model_valid[slot] = 1'b1;
    model_ip[slot]    = ip;
    model_mac[slot]   = mac;
    if (!found) model_rr = (model_rr + 1) % arp_entries;
  endtask

  function automatic net_pkg::arp_rsp_t predict_reply(input logic [31:0] ip);
    net_pkg::arp_rsp_t r;
    r.hit = 1'b0;
    r.mac = '0;
    r.ip  = ip;
    for (int i = 0; i < arp_entries; i++) begin
      if (model_valid[i] && model_ip[i] == ip) begin
        r.hit = 1'b1;
        r.mac = model_mac[i];
      end
    end
    return r;
  endfunction

  // Back-to-back calls keep valid high across the edge
  task automatic send_lookup(input logic [31:0] ip);
    net_pkg::arp_rsp_t r;
    arp_req_u_valid = 1'b1;
    arp_req_u.ip    = ip;
    #6;
    while (!arp_req_u_ready) begin
      step();
      #6;
    end
    r = predict_reply(ip);
    rsp_exp.push_back(r);
    model_lookups++;
    if (r.hit) model_hits++;
    step();
    arp_req_u_valid = 1'b0;
  endtask

  task automatic wait_replies();
    int n;
    n = 0;
    while (rsp_exp.size() != 0 && n < 300) begin
      step();
      n++;
    end
    if (rsp_exp.size() != 0) begin
      errors++;
      $display("Replies missing: %0d lookups never answered", rsp_exp.size());
    end
  endtask

  task automatic wait_cmds(input int n_ip, input int n_mac);
    int n;
    n = 0;
    while ((ip_seen.size() < n_ip || mac_seen.size() < n_mac) && n < 300) begin
      step();
      n++;
    end
    if (ip_seen.size() < n_ip || mac_seen.size() < n_mac) begin
      errors++;
      $display("Commands missing: only %0d set-IP and %0d set-MAC arrived",
               ip_seen.size(), mac_seen.size());
    end
  endtask

  // Reply ready toggles randomly only during the burst
  initial begin
    logic [31:0] r;
    arp_rsp_u_ready = 1'b1;
    forever begin
      @(posedge aclk);
      // Draw on the edge and drive 1 ns later
      r = rand32();
      #1;
      arp_rsp_u_ready = rand_ready ? r[0] : 1'b1;
    end
  end

  // Transfers seen late in the cycle complete on the next edge
  initial begin
    net_pkg::arp_rsp_t e;
    forever begin
      @(posedge aclk);
      #7;
      if (set_ip_n_valid && set_ip_n_ready) ip_seen.push_back(set_ip_n);
      if (set_mac_n_valid && set_mac_n_ready) mac_seen.push_back(set_mac_n);
      if (arp_rsp_u_valid && arp_rsp_u_ready) begin
        reply_count++;
        if (rsp_exp.size() == 0) begin
          errors++;
          $display("Reply for ip %h arrived with no lookup outstanding", arp_rsp_u.ip);
        end else begin
          e = rsp_exp.pop_front();
          expect_eq("reply hit", arp_rsp_u.hit, e.hit);
          expect_eq("reply ip", arp_rsp_u.ip, e.ip);
          if (e.hit) expect_eq("reply mac", arp_rsp_u.mac, e.mac);
        end
      end
    end
  end

  initial begin
    logic [31:0] rd, v, lo, hi, ip_old, ip_new;
    logic [31:0] bp_vals [6];
    logic [31:0] ips [arp_entries];
    int          base;
    rst_n           = 1'b0;
    apb_req         = '0;
    arp_req_u_valid = 1'b0;
    arp_req_u       = '0;
    set_ip_n_ready  = 1'b1;
    set_mac_n_ready = 1'b1;
    rand_ready      = 1'b0;
    for (int i = 0; i < arp_entries; i++) model_valid[i] = 1'b0;
    repeat (10) @(posedge aclk);
    #1;
    rst_n = 1'b1;

    // Idle outputs and all registers zero
    #6;
    expect_eq("idle arp_rsp_u_valid", arp_rsp_u_valid, 0);
    expect_eq("idle set_ip_n_valid", set_ip_n_valid, 0);
    expect_eq("idle set_mac_n_valid", set_mac_n_valid, 0);
    expect_eq("idle pready", apb_rsp.pready, 1);
    step();
    for (int a = 0; a < 32; a += 4) begin
      apb_read(8'(a), rd);
      expect_eq("register after reset", rd, 0);
    end
    report_test("reset_idle");

    // Set-IP and set-MAC commands
    v = rand32();
    apb_write(reg_ip, v);
    wait_cmds(1, 0);
    wait_cycles(2 * n_stages + 4);
    expect_eq("set_ip count", ip_seen.size(), 1);
    expect_eq("set_ip value", ip_seen[0], v);
    apb_read(reg_ip, rd);
    expect_eq("IP readback", rd, v);
    lo = rand32();
    hi = rand32();
    // Set-MAC waits at the network port for a few cycles
    set_mac_n_ready = 1'b0;
    apb_write(reg_mac_lo, lo);
    apb_write(reg_mac_hi, hi);
    wait_cycles(2 * n_stages + 4);
    set_mac_n_ready = 1'b1;
    wait_cmds(1, 1);
    wait_cycles(2 * n_stages + 4);
    expect_eq("set_mac count", mac_seen.size(), 1);
    expect_eq("set_mac value", mac_seen[0], {hi[15:0], lo});
    // Fill the stages so a later IP write has to wait
    set_ip_n_ready = 1'b0;
    ip_seen.delete();
    stall_seen = 0;
    fork
      begin
        for (int i = 0; i < 6; i++) begin
          bp_vals[i] = rand32();
          apb_write(reg_ip, bp_vals[i]);
        end
      end
      begin
        base = 0;
        while (stall_seen == 0 && base < 200) begin
          step();
          base++;
        end
        wait_cycles(3);
        set_ip_n_ready = 1'b1;
      end
    join
    if (stall_seen == 0) begin
      errors++;
      $display("pready was never stretched while set_ip_n was held off");
    end
    wait_cmds(6, 1);
    for (int i = 0; i < 6; i++) begin
      if (i < ip_seen.size()) expect_eq("set_ip order", ip_seen[i], bp_vals[i]);
    end
    report_test("commands");

    // Hits, misses and a replaced MAC
    for (int i = 0; i < arp_entries; i++) begin
      ips[i] = rand32();
      lo     = rand32();
      hi     = rand32();
      insert_entry(ips[i], {hi[15:0], lo});
    end
    for (int i = 0; i < arp_entries; i++) send_lookup(ips[i]);
    for (int i = 0; i < 4; i++) send_lookup(rand32());
    wait_replies();
    lo = rand32();
    insert_entry(ips[1], {16'hbeef, lo});
    send_lookup(ips[1]);
    wait_replies();
    report_test("lookup");

    // Fifth distinct IP replaces the round-robin victim
    ip_old = model_ip[model_rr];
    ip_new = rand32();
    lo     = rand32();
    insert_entry(ip_new, {16'h1234, lo});
    send_lookup(ip_old);
    send_lookup(ip_new);
    wait_replies();
    report_test("evict");

    // Burst under random reply ready
    rand_ready = 1'b1;
    base       = reply_count;
    for (int i = 0; i < 20; i++) begin
      v = rand32();
      send_lookup(v[0] ? model_ip[v[2:1]] : rand32());
    end
    wait_replies();
    rand_ready = 1'b0;
    expect_eq("burst reply count", reply_count - base, 20);
    report_test("burst");

    // Stats settle after the stage delay
    wait_cycles(n_stages + 4);
    apb_read(reg_lookups, rd);
    expect_eq("STAT_LOOKUPS", rd, model_lookups);
    apb_read(reg_hits, rd);
    expect_eq("STAT_HITS", rd, model_hits);
    report_test("stats");

    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, UUT.u_asserts.fail_count);
    if (errors == 0 && UUT.u_asserts.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
hw/net_pkg.sv
hw/axis_reg_slice.sv
hw/net_slice_array.sv
hw/net_cfg_regs.sv
hw/arp_cache.sv
hw/net_ctrl_top.sv
test/net_ctrl_asserts.sv
test/tb_net_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_net_ctrl \
  -f tb.f -o sim_net_ctrl &&
{
  out=$(./obj_dir/sim_net_ctrl)
  printf '%s\n' "$out"
  printf '%s\n' "$out" | grep -qx "All checks passed"
} &&
echo "PASS" || { echo "FAIL"; exit 1; }
